//--- Bender.yml
package:
  name: lsq

sources:
  - src/lsq_pkg.sv
  - src/lsq_agen.sv
  - src/lsq_store_queue.sv
  - src/lsq_load_queue.sv
  - src/lsq_top.sv
  - target: test
    files:
      - dv/lsq_properties.sv
      - dv/lsq_tb.sv

//--- dv/lsq_properties.sv
// lsq port assertions
`timescale 1ns/1ps

module lsq_properties (
	input logic               clock,
	input logic               reset,
	input lsq_pkg::dispatch_t dispatch,
	input logic               commit_valid,  // rob retire strobe
	input logic               mem_rsp_valid,
	input lsq_pkg::result_t   result_fwd,
	input lsq_pkg::result_t   result_mem,
	input lsq_pkg::mem_wr_t   mem_wr,
	input logic               mem_req_valid,
	input logic               sq_full,
	input logic               lq_full
);
	import lsq_pkg::*;

	int fail_cnt = 0; // failed assertions so far

	// everything quiet while held in reset
	a_reset_idle: assert property (@(posedge clock) reset |=> !result_fwd.valid &&
		!result_mem.valid && !mem_wr.valid && !mem_req_valid && !sq_full && !lq_full)
		else begin
			fail_cnt++;
			$error("outputs active during reset");
		end

	// a write needs a commit strobe the cycle before
	a_commit_wr: assert property (@(posedge clock) disable iff (reset)
		mem_wr.valid |-> $past(commit_valid))
		else begin
			fail_cnt++;
			$error("mem_wr without a commit one cycle earlier");
		end

	// response comes back one cycle later
	a_rsp_result: assert property (@(posedge clock) disable iff (reset)
		result_mem.valid == $past(mem_rsp_valid))
		else begin
			fail_cnt++;
			$error("result_mem not one cycle after mem_rsp_valid");
		end

	a_no_store_full: assert property (@(posedge clock) disable iff (reset)
		!((dispatch.op == OP_STORE) && sq_full))
		else begin
			fail_cnt++;
			$error("store dispatched while sq_full");
		end
	a_no_load_full: assert property (@(posedge clock) disable iff (reset)
		!((dispatch.op == OP_LOAD) && lq_full))
		else begin
			fail_cnt++;
			$error("load dispatched while lq_full");
		end

endmodule

bind lsq_top lsq_properties u_props (
	.clock(clock), .reset(reset), .dispatch(dispatch),
	.commit_valid(commit_valid), .mem_rsp_valid(mem_rsp_valid),
	.result_fwd(result_fwd), .result_mem(result_mem), .mem_wr(mem_wr),
	.mem_req_valid(mem_req_valid), .sq_full(sq_full), .lq_full(lq_full)
);

//--- dv/lsq_tb.sv
// load store queue testbench
`timescale 1ns/1ps

module lsq_tb;
	import lsq_pkg::*;

	localparam int N_OPS = 150;
	logic clock = 1'b0, reset;
	dispatch_t dispatch;
	logic commit_valid, mem_rsp_valid, mem_req_valid, sq_full, lq_full;
	logic [ROB_IDX_W-1:0] commit_rob_idx;
	logic [2:0] mem_rsp_tag, mem_req_tag;
	logic [XLEN-1:0] mem_rsp_data, mem_req_addr;
	result_t result_fwd, result_mem;
	mem_wr_t mem_wr;

	logic [31:0] stim_lfsr = 32'h37d4, mem_lfsr = 32'h37d4; // one stream per process
	logic [XLEN-1:0] mem [logic [XLEN-1:0]];     // memory model contents
	logic [XLEN-1:0] exp_mem [logic [XLEN-1:0]]; // expected after commits
	logic [XLEN-1:0] sq_a[$], sq_d[$], wq_a[$], wq_d[$];
	logic [ROB_IDX_W-1:0] sq_r[$];
	int sq_c[$], wq_c[$];                        // dispatch cycle, expected write cycle
	logic [XLEN-1:0] exp_data [64];              // per dest tag
	logic pending [64], is_fwd [64];
	int disp_cyc [64];
	logic rq_busy [8];                           // memory requests in flight
	logic [1:0] rq_cnt [8];
	logic [XLEN-1:0] rq_data [8];
	int cyc = 0, live = 0, miss_cnt = 0;
	logic [ROB_IDX_W-1:0] rob_ctr = '0, tag_ctr = '0;

	lsq_top #(.SQ_DEPTH(8), .LQ_DEPTH(8)) dut0 (.*);

	always #10 clock = ~clock;
	always @(posedge clock) cyc <= cyc + 1;

	// galois lfsr, one step per bit
	task automatic get_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = st[0] ? ((st >> 1) ^ 32'ha300_0000) : (st >> 1);
			v = {v[30:0], st[0]};
		end
	endtask

	function automatic logic [XLEN-1:0] fill(input logic [XLEN-1:0] a);
		return a ^ (a << 17) ^ 64'h5bd1_e995_0000_0000; // unwritten memory
	endfunction

	task automatic fail_now(input string msg);
		$display("Fail %0t %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic idle();
		dispatch = '0;
		commit_valid = 1'b0;
		commit_rob_idx = '0;
	endtask

	task automatic send_op(input lsq_op_e op, output logic [XLEN-1:0] a);
		logic [31:0] p, o, d0, d1;
		get_bits(stim_lfsr, 2, p);             // small pool, frequent matches
		get_bits(stim_lfsr, 4, o);
		get_bits(stim_lfsr, 32, d0);
		get_bits(stim_lfsr, 32, d1);
		a = 64'h1000 + 64'(p) * 8;
		dispatch = '{op: op, rob_idx: rob_ctr, base: a - 64'(o), offset: 64'(o),
			data: {d0, d1}, dest_tag: tag_ctr};
	endtask

	task automatic issue_store();
		logic [XLEN-1:0] a;
		send_op(OP_STORE, a);
		sq_a.push_back(a);
		sq_d.push_back(dispatch.data);
		sq_r.push_back(rob_ctr);
		sq_c.push_back(cyc);
		rob_ctr++;
	endtask

	task automatic issue_load();
		logic [XLEN-1:0] a;
		send_op(OP_LOAD, a);
		assert (!pending[tag_ctr]) else fail_now("dest tag reused while pending");
		is_fwd[tag_ctr] = 1'b0;
		for (int i = 0; i < sq_a.size(); i++) begin
			if (sq_a[i] == a) begin // last match is youngest
				is_fwd[tag_ctr] = 1'b1;
				exp_data[tag_ctr] = sq_d[i];
			end
		end
		if (!is_fwd[tag_ctr]) begin
			exp_data[tag_ctr] = exp_mem.exists(a) ? exp_mem[a] : fill(a);
			miss_cnt++;
		end
		pending[tag_ctr] = 1'b1;
		disp_cyc[tag_ctr] = cyc;
		live++;
		tag_ctr++;
	endtask

	// good commits retire the head, bad ones must be ignored
	// head store sits in the queue two edges after dispatch
	task automatic commit_head(input logic good);
		if (sq_a.size() == 0 || cyc < sq_c[0] + 2) return;
		commit_valid = 1'b1;
		commit_rob_idx = good ? sq_r[0] : sq_r[0] ^ 6'h20;
		if (good) begin
			exp_mem[sq_a[0]] = sq_d[0];
			wq_a.push_back(sq_a.pop_front());
			wq_d.push_back(sq_d.pop_front());
			wq_c.push_back(cyc + 1);
			void'(sq_r.pop_front());
			void'(sq_c.pop_front());
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin : stim
		logic [31:0] r;
		for (int i = 0; i < 64; i++) pending[i] = 1'b0;
		for (int i = 0; i < 8; i++) rq_busy[i] = 1'b0;
		idle();
		reset = 1'b1;
		mem_rsp_valid = 1'b0;
		mem_rsp_tag = '0;
		mem_rsp_data = '0;
		repeat (5) @(posedge clock);
		@(negedge clock) reset = 1'b0;
		for (int k = 0; k < N_OPS; k++) begin
			@(negedge clock);
			idle();
			get_bits(stim_lfsr, 2, r);
			case (r[1:0])
				2'd0: if (!sq_full) issue_store();
				2'd1: if (!lq_full) issue_load();
				// no read may race a write
				2'd2: if (miss_cnt == 0 && !result_mem.valid) commit_head(1'b1);
				default: commit_head(1'b0);
			endcase
		end
		while (sq_a.size() > 0) begin // drain the store queue
			@(negedge clock);
			idle();
			if (miss_cnt == 0 && !result_mem.valid) commit_head(1'b1);
		end
		@(negedge clock) idle();
		while (live > 0 || wq_a.size() > 0) @(negedge clock);
		repeat (3) @(negedge clock);
		if (dut0.u_props.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "bound assertion failed");
		end
	end

	// memory model, reads before writes
	always @(negedge clock) begin : mem_model
		logic [31:0] d;
		logic sent;
		sent = 1'b0;
		mem_rsp_valid = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (!reset && rq_busy[i] && rq_cnt[i] == 0 && !sent) begin
				mem_rsp_valid = 1'b1;
				mem_rsp_tag = 3'(i);
				mem_rsp_data = rq_data[i];
				rq_busy[i] = 1'b0;
				sent = 1'b1;
			end else if (rq_busy[i] && rq_cnt[i] != 0) rq_cnt[i]--;
		end
		if (!reset && mem_req_valid) begin
			get_bits(mem_lfsr, 2, d);            // 1 to 4 cycles
			rq_busy[mem_req_tag] = 1'b1;
			rq_cnt[mem_req_tag] = d[1:0];
			rq_data[mem_req_tag] = mem.exists(mem_req_addr) ?
				mem[mem_req_addr] : fill(mem_req_addr);
		end
		if (!reset && mem_wr.valid) mem[mem_wr.addr] = mem_wr.data;
	end

	////////////////////////////////////////////////////////////
	// scoreboard checks
	////////////////////////////////////////////////////////////
	always @(negedge clock) begin : checks
		if (dut0.u_props.fail_cnt != 0) fail_now("a bound port assertion failed");
		if (reset) begin
			if (cyc > 0) assert (!result_fwd.valid && !result_mem.valid && !mem_wr.valid &&
				!mem_req_valid && !sq_full && !lq_full) else fail_now("output active in reset");
		end else begin
			if (result_fwd.valid) begin
				assert (pending[result_fwd.dest_tag] && is_fwd[result_fwd.dest_tag])
					else fail_now("unexpected forward result");
				assert (result_fwd.data == exp_data[result_fwd.dest_tag])
					else fail_now("forward data mismatch");
				assert (cyc == disp_cyc[result_fwd.dest_tag] + 2)
					else fail_now("forward not 2 cycles after dispatch");
				pending[result_fwd.dest_tag] = 1'b0;
				live--;
			end
			if (result_mem.valid) begin
				assert (pending[result_mem.dest_tag] && !is_fwd[result_mem.dest_tag])
					else fail_now("unexpected memory result");
				assert (result_mem.data == exp_data[result_mem.dest_tag])
					else fail_now("memory result data mismatch");
				pending[result_mem.dest_tag] = 1'b0;
				live--;
				miss_cnt--;
			end
			if (mem_wr.valid) begin
				assert (wq_a.size() > 0) else fail_now("mem_wr without a matching commit");
				assert (mem_wr.addr == wq_a[0] && mem_wr.data == wq_d[0])
					else fail_now("mem_wr out of order or wrong");
				assert (cyc == wq_c[0]) else fail_now("mem_wr not 1 cycle after commit");
				void'(wq_a.pop_front());
				void'(wq_d.pop_front());
				void'(wq_c.pop_front());
			end else if (wq_c.size() > 0) begin
				assert (cyc < wq_c[0]) else fail_now("head commit gave no mem_wr");
			end
		end
	end

	initial begin : watchdog
		#(20 * (20 * N_OPS + 200 + 5));
		$display("watchdog timeout, the DUT stopped making progress");
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

//--- flist.f
src/lsq_pkg.sv
src/lsq_agen.sv
src/lsq_store_queue.sv
src/lsq_load_queue.sv
src/lsq_top.sv
dv/lsq_properties.sv
dv/lsq_tb.sv

//--- src/lsq_agen.sv
// load store address generation
`timescale 1ns/1ps

module lsq_agen (
	input  logic                clock,
	input  logic                reset,
	input  lsq_pkg::dispatch_t  dispatch, // one op per cycle, strobe
	output lsq_pkg::mem_op_t    agen_op   // registered op with address
);
	import lsq_pkg::*;

	logic [XLEN-1:0] eff_addr;

	// base plus displacement
	// no translation, address goes straight to the queues
	assign eff_addr = dispatch.base + dispatch.offset;

	////////////////////////////////////////////////////////////
	// dispatch register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		// payload follows dispatch every cycle
		agen_op.rob_idx  <= dispatch.rob_idx;
		agen_op.addr     <= eff_addr;
		agen_op.data     <= dispatch.data;     // only meaningful for stores
		agen_op.dest_tag <= dispatch.dest_tag; // only meaningful for loads

		// op decides whether the slot holds anything
		if (reset) begin
			agen_op.op <= OP_NONE;
		end else begin
			agen_op.op <= dispatch.op; // bubble when dispatch idle
		end
	end

	// store queue sees this op one cycle after dispatch
	// load queue sees it together with the miss flag
	// so a store here is visible to a load one cycle behind

endmodule

//--- src/lsq_load_queue.sv
// load miss queue
`timescale 1ns/1ps

module lsq_load_queue #(
	parameter int LQ_DEPTH = lsq_pkg::LQ_DEPTH_DEF
) (
	input  logic                            clock,
	input  logic                            reset,
	input  lsq_pkg::mem_op_t                agen_op,
	input  logic                            load_miss,     // from store queue search
	input  logic                            mem_rsp_valid,
	input  logic [$clog2(LQ_DEPTH)-1:0]     mem_rsp_tag,   // slot number of the load
	input  logic [lsq_pkg::XLEN-1:0]        mem_rsp_data,
	output logic                            mem_req_valid,
	output logic [lsq_pkg::XLEN-1:0]        mem_req_addr,
	output logic [$clog2(LQ_DEPTH)-1:0]     mem_req_tag,
	output lsq_pkg::result_t                result_mem,    // memory data to the prf
	output logic                            lq_full
);
	import lsq_pkg::*;

	localparam int TAG_W = $clog2(LQ_DEPTH);
	localparam int AGE_W = TAG_W + 1;      // room past the worst wait

	// slot contents
	logic [XLEN-1:0]      lq_addr  [LQ_DEPTH];
	logic [PRF_TAG_W-1:0] lq_tag   [LQ_DEPTH];
	logic [AGE_W-1:0]     lq_age   [LQ_DEPTH]; // cycles spent waiting to issue
	lq_state_e            lq_state [LQ_DEPTH];

	logic             alloc_ok;
	logic [TAG_W-1:0] alloc_idx;
	logic [TAG_W:0]   free_cnt;
	logic             pick_ok;
	logic [TAG_W-1:0] pick_idx;
	logic [AGE_W-1:0] pick_age;

	////////////////////////////////////////////////////////////
	// slot allocation and request picker
	////////////////////////////////////////////////////////////
	always_comb begin
		alloc_ok  = 1'b0;
		alloc_idx = '0;
		free_cnt  = '0;
		pick_ok   = 1'b0;
		pick_idx  = '0;
		pick_age  = '0;
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (lq_state[i] == LQ_FREE) begin
				free_cnt = free_cnt + 1'b1;
				if (!alloc_ok) begin // lowest free slot
					alloc_ok  = 1'b1;
					alloc_idx = TAG_W'(i);
				end
			end
			// oldest waiter, ties to lower slot
			if ((lq_state[i] == LQ_WAIT_REQ) && (!pick_ok || (lq_age[i] > pick_age))) begin
				pick_ok  = 1'b1;
				pick_idx = TAG_W'(i);
				pick_age = lq_age[i];
			end
		end
	end

	// agen load may still claim a slot
	assign lq_full = (free_cnt == '0) || ((free_cnt == 1) && (agen_op.op == OP_LOAD));

	// slot payload written on a miss
	always_ff @(posedge clock) begin
		if (load_miss && alloc_ok) begin
			lq_addr[alloc_idx] <= agen_op.addr;
			lq_tag[alloc_idx]  <= agen_op.dest_tag;
		end
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if ((lq_state[i] == LQ_WAIT_REQ) && (lq_age[i] != '1)) begin
				lq_age[i] <= lq_age[i] + 1'b1; // saturates
			end
		end
		if (load_miss && alloc_ok) begin
			lq_age[alloc_idx] <= '0; // new waiter starts young
		end
	end

	////////////////////////////////////////////////////////////
	// slot states, request and response
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		mem_req_addr        <= lq_addr[pick_idx];
		mem_req_tag         <= pick_idx;          // slot doubles as the tag
		result_mem.dest_tag <= lq_tag[mem_rsp_tag];
		result_mem.data     <= mem_rsp_data;
		if (reset) begin
			for (int i = 0; i < LQ_DEPTH; i++) begin
				lq_state[i] <= LQ_FREE;
			end
			mem_req_valid    <= 1'b0;
			result_mem.valid <= 1'b0;
		end else begin
			mem_req_valid    <= pick_ok;          // one request per cycle
			result_mem.valid <= mem_rsp_valid;
			// alloc, pick and response always hit different slots
			if (load_miss && alloc_ok) begin
				lq_state[alloc_idx] <= LQ_WAIT_REQ;
			end
			if (pick_ok) begin
				lq_state[pick_idx] <= LQ_WAIT_MEM;
			end
			if (mem_rsp_valid) begin
				lq_state[mem_rsp_tag] <= LQ_FREE; // load done
			end
		end
	end

endmodule

//--- src/lsq_pkg.sv
// load store queue shared types
package lsq_pkg;

	////////////////////////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////////////////////////
	localparam int XLEN         = 64; // data and address width
	localparam int ROB_IDX_W    = 6;  // rob index incl wrap bit
	localparam int PRF_TAG_W    = 6;  // physical dest tag
	localparam int SQ_DEPTH_DEF = 8;  // default store queue depth
	localparam int LQ_DEPTH_DEF = 8;  // default load queue depth

	////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0, // bubble
		OP_LOAD  = 2'd1,
		OP_STORE = 2'd2
	} lsq_op_e;

	// load slot life cycle
	typedef enum logic [1:0] {
		LQ_FREE     = 2'd0, // slot empty
		LQ_WAIT_REQ = 2'd1, // missed, request not yet sent
		LQ_WAIT_MEM = 2'd2  // request out, waiting on response
	} lq_state_e;

	////////////////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////////////////

	// one op from dispatch, operands already ready
	typedef struct packed {
		lsq_op_e                op;
		logic [ROB_IDX_W-1:0]   rob_idx;
		logic [XLEN-1:0]        base;     // base register value
		logic [XLEN-1:0]        offset;   // sign extended displacement
		logic [XLEN-1:0]        data;     // store data
		logic [PRF_TAG_W-1:0]   dest_tag; // load destination
	} dispatch_t;

	// op after address generation
	typedef struct packed {
		lsq_op_e                op;
		logic [ROB_IDX_W-1:0]   rob_idx;
		logic [XLEN-1:0]        addr;     // effective address
		logic [XLEN-1:0]        data;
		logic [PRF_TAG_W-1:0]   dest_tag;
	} mem_op_t;

	// result broadcast to the prf
	typedef struct packed {
		logic                   valid;
		logic [PRF_TAG_W-1:0]   dest_tag;
		logic [XLEN-1:0]        data;
	} result_t;

	// committed store going to memory
	typedef struct packed {
		logic                   valid;
		logic [XLEN-1:0]        addr;
		logic [XLEN-1:0]        data;
	} mem_wr_t;

endpackage

//--- src/lsq_store_queue.sv
// in order store queue
`timescale 1ns/1ps

module lsq_store_queue #(
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH_DEF
) (
	input  logic                            clock,
	input  logic                            reset,
	input  lsq_pkg::mem_op_t                agen_op,
	input  logic                            commit_valid,   // rob retire strobe
	input  logic [lsq_pkg::ROB_IDX_W-1:0]   commit_rob_idx,
	output logic                            load_miss,      // agen load found no store
	output lsq_pkg::result_t                result_fwd,     // forwarded load data
	output lsq_pkg::mem_wr_t                mem_wr,         // committed store write
	output logic                            sq_full
);
	import lsq_pkg::*;

	localparam int PTR_W = $clog2(SQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// entry storage, no reset needed
	logic [XLEN-1:0]      sq_addr [SQ_DEPTH];
	logic [XLEN-1:0]      sq_data [SQ_DEPTH];
	logic [ROB_IDX_W-1:0] sq_rob  [SQ_DEPTH];

	logic [CNT_W-1:0] head, tail;           // msb is the wrap bit
	logic [CNT_W-1:0] sq_count;
	logic [PTR_W-1:0] head_idx, tail_idx;
	logic [PTR_W-1:0] scan_idx;
	logic             fwd_hit;
	logic [XLEN-1:0]  fwd_data;
	logic             commit_hit;
	logic             st_in, ld_in;

	assign head_idx = head[PTR_W-1:0];
	assign tail_idx = tail[PTR_W-1:0];
	assign sq_count = tail - head;          // wrap bit makes full and empty distinct

	assign st_in = (agen_op.op == OP_STORE);
	assign ld_in = (agen_op.op == OP_LOAD);

	// stalls dispatch early since a store may already sit in agen
	assign sq_full = (sq_count == CNT_W'(SQ_DEPTH)) ||
		((sq_count == CNT_W'(SQ_DEPTH - 1)) && st_in);

	////////////////////////////////////////////////////////////
	// forwarding search
	////////////////////////////////////////////////////////////
	// walk back from the tail, first hit is the youngest older store
	always_comb begin
		fwd_hit  = 1'b0;
		fwd_data = '0;
		scan_idx = tail_idx;
		for (int i = 0; i < SQ_DEPTH; i++) begin
			scan_idx = tail_idx - PTR_W'(i) - 1'b1;
			if (!fwd_hit && (CNT_W'(i) < sq_count) && (sq_addr[scan_idx] == agen_op.addr)) begin
				fwd_hit  = 1'b1;
				fwd_data = sq_data[scan_idx];
			end
		end
	end

	assign load_miss = ld_in && !fwd_hit; // load queue takes it from here

	// head only retires on its own rob index
	assign commit_hit = commit_valid && (sq_count != '0) &&
		(commit_rob_idx == sq_rob[head_idx]);

	// append at tail
	always_ff @(posedge clock) begin
		if (st_in) begin
			sq_addr[tail_idx] <= agen_op.addr;
			sq_data[tail_idx] <= agen_op.data;
			sq_rob[tail_idx]  <= agen_op.rob_idx;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers and outputs
	////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		result_fwd.dest_tag <= agen_op.dest_tag;
		result_fwd.data     <= fwd_data;
		mem_wr.addr         <= sq_addr[head_idx]; // head entry to memory
		mem_wr.data         <= sq_data[head_idx];
		if (reset) begin
			head             <= '0;
			tail             <= '0;
			result_fwd.valid <= 1'b0;
			mem_wr.valid     <= 1'b0;
		end else begin
			result_fwd.valid <= ld_in && fwd_hit;
			mem_wr.valid     <= commit_hit;
			if (commit_hit) begin
				head <= head + 1'b1; // pop
			end
			if (st_in) begin
				tail <= tail + 1'b1; // push
			end
		end
	end

endmodule

//--- src/lsq_top.sv
// load store queue top
`timescale 1ns/1ps

module lsq_top #(
	parameter int SQ_DEPTH = lsq_pkg::SQ_DEPTH_DEF, // power of two
	parameter int LQ_DEPTH = lsq_pkg::LQ_DEPTH_DEF  // power of two
) (
	input  logic                            clock,
	input  logic                            reset,
	input  lsq_pkg::dispatch_t              dispatch,
	input  logic                            commit_valid,
	input  logic [lsq_pkg::ROB_IDX_W-1:0]   commit_rob_idx,
	input  logic                            mem_rsp_valid,
	input  logic [$clog2(LQ_DEPTH)-1:0]     mem_rsp_tag,
	input  logic [lsq_pkg::XLEN-1:0]        mem_rsp_data,
	output lsq_pkg::result_t                result_fwd,    // store to load forward
	output lsq_pkg::result_t                result_mem,    // memory return
	output lsq_pkg::mem_wr_t                mem_wr,
	output logic                            mem_req_valid,
	output logic [lsq_pkg::XLEN-1:0]        mem_req_addr,
	output logic [$clog2(LQ_DEPTH)-1:0]     mem_req_tag,
	output logic                            sq_full,
	output logic                            lq_full
);
	import lsq_pkg::*;

	mem_op_t agen_op;   // shared by both queues
	logic    load_miss; // sq search to lq

	// stage 1
	lsq_agen u_agen (
		.clock    (clock),
		.reset    (reset),
		.dispatch (dispatch),
		.agen_op  (agen_op)
	);

	// stage 2 forwarding search and commit
	lsq_store_queue #(
		.SQ_DEPTH (SQ_DEPTH)
	) u_store_queue (
		.clock          (clock),
		.reset          (reset),
		.agen_op        (agen_op),
		.commit_valid   (commit_valid),
		.commit_rob_idx (commit_rob_idx),
		.load_miss      (load_miss),
		.result_fwd     (result_fwd),
		.mem_wr         (mem_wr),
		.sq_full        (sq_full)
	);

	// stage 3 misses go to memory
	lsq_load_queue #(
		.LQ_DEPTH (LQ_DEPTH)
	) u_load_queue (
		.clock         (clock),
		.reset         (reset),
		.agen_op       (agen_op),
		.load_miss     (load_miss),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_tag   (mem_rsp_tag),
		.mem_rsp_data  (mem_rsp_data),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.mem_req_tag   (mem_req_tag),
		.result_mem    (result_mem),
		.lq_full       (lq_full)
	);

endmodule
